/* common/dpath_defines.svh */
/* Datapath width and reset constants, shared by the package and the RTL.
   Widths other than RV32 are untested and the immediate layout assumes 32 */

`ifndef DPATH_DEFINES_SVH
`define DPATH_DEFINES_SVH

// Data and address width
`define DPATH_XLEN 32

// Register file geometry
`define DPATH_REG_AW   5
`define DPATH_NUM_REGS 32

// Sequential fetch step, bytes
`define DPATH_PC_STEP 4

// First fetch address after reset
`define DPATH_RESET_VECTOR 32'h00080000

`endif

/* common/dpath_pkg.sv */
/* Types and select encodings for the RV32 datapath.
   Select encodings follow the existing controller, so keep them fixed */

`include "dpath_defines.svh"

package dpath_pkg;

  typedef logic [`DPATH_XLEN-1:0]   word_t;      // Data word and address
  typedef logic [`DPATH_REG_AW-1:0] reg_addr_t;  // Register specifier

  // Operand 0 source, sampled in D
  typedef enum logic [1:0] {
    OP0_RDAT = 2'd0,  // rs1 value
    OP0_PC   = 2'd1,
    OP0_PC4  = 2'd2,
    OP0_ZERO = 2'd3
  } op0_sel_t;

  // Operand 1 source, sampled in D
  typedef enum logic [2:0] {
    OP1_RDAT   = 3'd0,  // rs2 value
    OP1_SHAMT  = 3'd1,  // Zero-extended shift amount
    OP1_IMM_U  = 3'd2,
    OP1_IMM_SB = 3'd3,
    OP1_IMM_I  = 3'd4,
    OP1_IMM_S  = 3'd5,
    OP1_ZERO   = 3'd6
  } op1_sel_t;

  // ALU function, sampled in X
  typedef enum logic [3:0] {
    ALU_ADD = 4'd0,
    ALU_SUB = 4'd1,
    ALU_SLL = 4'd2,
    ALU_OR  = 4'd3,
    ALU_LT  = 4'd4,
    ALU_LTU = 4'd5,
    ALU_AND = 4'd6,
    ALU_XOR = 4'd7,
    ALU_NOR = 4'd8,
    ALU_SRL = 4'd9,
    ALU_SRA = 4'd10
  } alu_fn_t;

  // Redirect target kind, code 0 is unused
  typedef enum logic [1:0] {
    BRJ_BR   = 2'd1,
    BRJ_JAL  = 2'd2,
    BRJ_JALR = 2'd3
  } brj_sel_t;

  // Load extraction, sampled in M
  typedef enum logic [2:0] {
    LD_W  = 3'd0,
    LD_B  = 3'd1,
    LD_BU = 3'd2,
    LD_H  = 3'd3,
    LD_HU = 3'd4
  } load_sel_t;

  // Writeback source
  typedef enum logic {
    WB_EXE = 1'b0,
    WB_MEM = 1'b1
  } wb_sel_t;

endpackage

/* src/fetch_unit.sv */
/* PC and F-to-D registers. A redirect loads the PC directly, with no flush.
   A redirect seen while stalled is taken on the first unstalled edge */

`timescale 1ns/10ps
`include "dpath_defines.svh"

module fetch_unit (
  input  logic            clk,
  input  logic            reset,
  input  logic            stall,
  input  logic            redirect_x,       // Taken branch or jump in X
  input  dpath_pkg::word_t redirect_target,
  output dpath_pkg::word_t imem_addr,
  output dpath_pkg::word_t pc_d,
  output dpath_pkg::word_t pc_plus4_d
);

  dpath_pkg::word_t pc;
  dpath_pkg::word_t pc_plus4;

  assign pc_plus4  = pc + `DPATH_PC_STEP;
  assign imem_addr = pc;  // Instruction returns in D next cycle

  // PC register
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `DPATH_RESET_VECTOR;
    end else if (!stall) begin
      pc <= redirect_x ? redirect_target : pc_plus4;
    end
  end

  // ------------------------------------------------------------------------
  // F to D
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      pc_d       <= '0;
      pc_plus4_d <= '0;
    end else if (!stall) begin
      pc_d       <= pc;
      pc_plus4_d <= pc_plus4;  // Link value for jal/jalr
    end
  end

endmodule

/* decode/regfile.sv */
/* 32-entry register file, two asynchronous reads and one synchronous write.
   No write-through, so a same-cycle write shows on the next read */

`timescale 1ns/10ps
`include "dpath_defines.svh"

module regfile (
  input  logic                 clk,
  input  dpath_pkg::reg_addr_t raddr0,
  input  dpath_pkg::reg_addr_t raddr1,
  input  dpath_pkg::reg_addr_t waddr,
  input  logic                 wen,
  input  dpath_pkg::word_t     wdata,
  output dpath_pkg::word_t     rdata0,
  output dpath_pkg::word_t     rdata1
);

  dpath_pkg::word_t regs [`DPATH_NUM_REGS];  // Contents undefined until written

  always_ff @(posedge clk) begin
    if (wen && (waddr != '0)) begin  // x0 ignores writes
      regs[waddr] <= wdata;
    end
  end

  // x0 always reads zero
  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

endmodule

/* decode/decode_unit.sv */
/* Decode stage. Register read, immediates, operand selection, D-to-X regs.
   No forwarding, the controller spaces dependent instructions */

`timescale 1ns/10ps
`include "dpath_defines.svh"

module decode_unit (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  stall,
  input  dpath_pkg::word_t      inst_d,
  input  dpath_pkg::word_t      pc_d,
  input  dpath_pkg::word_t      pc_plus4_d,
  input  dpath_pkg::op0_sel_t   op0_sel_d,
  input  dpath_pkg::op1_sel_t   op1_sel_d,
  input  logic                  rf_wen_w,
  input  dpath_pkg::reg_addr_t  rf_waddr_w,
  input  dpath_pkg::word_t      wb_data,
  output dpath_pkg::word_t      pc_x,
  output dpath_pkg::word_t      op0_x,
  output dpath_pkg::word_t      op1_x,
  output dpath_pkg::word_t      rs1_x,
  output dpath_pkg::word_t      rs2_x,
  output dpath_pkg::word_t      imm_i_x,
  output dpath_pkg::word_t      imm_sb_x,
  output dpath_pkg::word_t      imm_uj_x
);

  dpath_pkg::reg_addr_t rs1_addr;
  dpath_pkg::reg_addr_t rs2_addr;
  dpath_pkg::word_t     rs1_val;
  dpath_pkg::word_t     rs2_val;
  dpath_pkg::word_t     imm_i, imm_s, imm_sb, imm_u, imm_uj, shamt;
  dpath_pkg::word_t     op0, op1;

  // ------------------------------------------------------------------------
  // Fields and immediates
  // ------------------------------------------------------------------------
  assign rs1_addr = inst_d[19:15];
  assign rs2_addr = inst_d[24:20];

  assign imm_i  = {{20{inst_d[31]}}, inst_d[31:20]};
  assign imm_s  = {{20{inst_d[31]}}, inst_d[31:25], inst_d[11:7]};
  assign imm_sb = {{20{inst_d[31]}}, inst_d[7], inst_d[30:25], inst_d[11:8], 1'b0};
  assign imm_u  = {inst_d[31:12], 12'b0};
  assign imm_uj = {{12{inst_d[31]}}, inst_d[19:12], inst_d[20], inst_d[30:21], 1'b0};
  assign shamt  = {{(`DPATH_XLEN-5){1'b0}}, inst_d[24:20]};  // Same bits as rs2

  regfile u_regfile (
    .clk    (clk),
    .raddr0 (rs1_addr),
    .raddr1 (rs2_addr),
    .waddr  (rf_waddr_w),
    .wen    (rf_wen_w),     // Not frozen by stall
    .wdata  (wb_data),
    .rdata0 (rs1_val),
    .rdata1 (rs2_val)
  );

  // Operand muxes
  always_comb begin
    case (op0_sel_d)
      dpath_pkg::OP0_RDAT: op0 = rs1_val;
      dpath_pkg::OP0_PC:   op0 = pc_d;
      dpath_pkg::OP0_PC4:  op0 = pc_plus4_d;
      default:             op0 = '0;  // OP0_ZERO
    endcase
  end

  always_comb begin
    case (op1_sel_d)
      dpath_pkg::OP1_RDAT:   op1 = rs2_val;
      dpath_pkg::OP1_SHAMT:  op1 = shamt;
      dpath_pkg::OP1_IMM_U:  op1 = imm_u;
      dpath_pkg::OP1_IMM_SB: op1 = imm_sb;
      dpath_pkg::OP1_IMM_I:  op1 = imm_i;
      dpath_pkg::OP1_IMM_S:  op1 = imm_s;
      default:               op1 = '0;  // OP1_ZERO and unused code
    endcase
  end

  // ------------------------------------------------------------------------
  // D to X
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      pc_x     <= '0;
      op0_x    <= '0;
      op1_x    <= '0;
      rs1_x    <= '0;
      rs2_x    <= '0;
      imm_i_x  <= '0;
      imm_sb_x <= '0;
      imm_uj_x <= '0;
    end else if (!stall) begin
      pc_x     <= pc_d;
      op0_x    <= op0;
      op1_x    <= op1;
      rs1_x    <= rs1_val;  // jalr base
      rs2_x    <= rs2_val;  // Store data
      imm_i_x  <= imm_i;
      imm_sb_x <= imm_sb;
      imm_uj_x <= imm_uj;
    end
  end

endmodule

/* execute/alu.sv */
/* Combinational ALU. Shifts take in1[4:0], compares return 0 or 1.
   Unused function codes give zero */

`timescale 1ns/10ps

module alu (
  input  dpath_pkg::word_t   in0,
  input  dpath_pkg::word_t   in1,
  input  dpath_pkg::alu_fn_t fn,
  output dpath_pkg::word_t   result
);

  logic [4:0] sh;

  assign sh = in1[4:0];

  always_comb begin
    case (fn)
      dpath_pkg::ALU_ADD: result = in0 + in1;
      dpath_pkg::ALU_SUB: result = in0 - in1;
      dpath_pkg::ALU_SLL: result = in0 << sh;
      dpath_pkg::ALU_OR:  result = in0 | in1;
      dpath_pkg::ALU_LT:  result = {31'b0, $signed(in0) < $signed(in1)};
      dpath_pkg::ALU_LTU: result = {31'b0, in0 < in1};
      dpath_pkg::ALU_AND: result = in0 & in1;
      dpath_pkg::ALU_XOR: result = in0 ^ in1;
      dpath_pkg::ALU_NOR: result = ~(in0 | in1);
      dpath_pkg::ALU_SRL: result = in0 >> sh;
      dpath_pkg::ALU_SRA: result = $signed(in0) >>> sh;  // Sign fill
      default:            result = '0;
    endcase
  end

endmodule

/* execute/execute_unit.sv */
/* Execute stage. ALU, branch flags, redirect target, data-memory request.
   Memory address and store data are combinational in X, read data in M */

`timescale 1ns/10ps
`include "dpath_defines.svh"

module execute_unit (
  input  logic                clk,
  input  logic                reset,
  input  logic                stall,
  input  logic                brj_taken_x,
  input  dpath_pkg::word_t    pc_x,
  input  dpath_pkg::word_t    op0_x,
  input  dpath_pkg::word_t    op1_x,
  input  dpath_pkg::word_t    rs1_x,
  input  dpath_pkg::word_t    rs2_x,
  input  dpath_pkg::word_t    imm_i_x,
  input  dpath_pkg::word_t    imm_sb_x,
  input  dpath_pkg::word_t    imm_uj_x,
  input  dpath_pkg::alu_fn_t  alu_fn_x,
  input  dpath_pkg::brj_sel_t brj_sel_x,
  output dpath_pkg::word_t    dmem_addr,
  output dpath_pkg::word_t    dmem_wdata,
  output dpath_pkg::word_t    exe_m,
  output dpath_pkg::word_t    redirect_target,
  output logic                redirect_x,
  output logic                cond_eq_x,
  output logic                cond_ne_x,
  output logic                cond_lt_x,
  output logic                cond_ltu_x,
  output logic                cond_ge_x,
  output logic                cond_geu_x
);

  dpath_pkg::word_t alu_out;
  dpath_pkg::word_t jalr_sum;

  alu u_alu (
    .in0    (op0_x),
    .in1    (op1_x),
    .fn     (alu_fn_x),
    .result (alu_out)
  );

  // Branch flags for the controller
  assign cond_eq_x  = (op0_x == op1_x);
  assign cond_ne_x  = (op0_x != op1_x);
  assign cond_lt_x  = ($signed(op0_x) < $signed(op1_x));
  assign cond_ltu_x = (op0_x < op1_x);
  assign cond_ge_x  = ($signed(op0_x) >= $signed(op1_x));
  assign cond_geu_x = (op0_x >= op1_x);

  // ------------------------------------------------------------------------
  // Redirect target
  // ------------------------------------------------------------------------
  assign jalr_sum = rs1_x + imm_i_x;

  always_comb begin
    case (brj_sel_x)
      dpath_pkg::BRJ_BR:   redirect_target = pc_x + imm_sb_x;
      dpath_pkg::BRJ_JAL:  redirect_target = pc_x + imm_uj_x;
      dpath_pkg::BRJ_JALR: redirect_target = {jalr_sum[31:1], 1'b0};  // Bit 0 cleared
      default:             redirect_target = pc_x + `DPATH_PC_STEP;   // Fall-through
    endcase
  end

  assign redirect_x = brj_taken_x;  // Decision made by the controller

  assign dmem_addr  = alu_out;  // Effective address
  assign dmem_wdata = rs2_x;

  // X to M, ALU result only
  always_ff @(posedge clk) begin
    if (reset) begin
      exe_m <= '0;
    end else if (!stall) begin
      exe_m <= alu_out;
    end
  end

endmodule

/* src/memory_writeback.sv */
/* Memory stage load extraction and writeback mux, registered into W.
   Loads take the low byte or halfword only, no address-based lane shift */

`timescale 1ns/10ps

module memory_writeback (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 stall,
  input  dpath_pkg::word_t     exe_m,
  input  dpath_pkg::word_t     dmem_rdata,
  input  dpath_pkg::load_sel_t load_sel_m,
  input  dpath_pkg::wb_sel_t   wb_sel_m,
  output dpath_pkg::word_t     wb_data
);

  dpath_pkg::word_t load_data;
  dpath_pkg::word_t wb_mux;

  // Subword extraction
  always_comb begin
    case (load_sel_m)
      dpath_pkg::LD_B:  load_data = {{24{dmem_rdata[7]}}, dmem_rdata[7:0]};
      dpath_pkg::LD_BU: load_data = {24'b0, dmem_rdata[7:0]};
      dpath_pkg::LD_H:  load_data = {{16{dmem_rdata[15]}}, dmem_rdata[15:0]};
      dpath_pkg::LD_HU: load_data = {16'b0, dmem_rdata[15:0]};
      default:          load_data = dmem_rdata;  // LD_W
    endcase
  end

  assign wb_mux = (wb_sel_m == dpath_pkg::WB_MEM) ? load_data : exe_m;

  // M to W
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_data <= '0;
    end else if (!stall) begin
      wb_data <= wb_mux;  // Also the register-file write data
    end
  end

endmodule

/* src/core_dpath.sv */
/* Five-stage RV32 datapath top. Controls arrive per stage from outside.
   One stall freezes all pipeline registers, memories have fixed latency */

`timescale 1ns/10ps

module core_dpath (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 stall,
  input  dpath_pkg::word_t     inst_d,
  input  dpath_pkg::op0_sel_t  op0_sel_d,
  input  dpath_pkg::op1_sel_t  op1_sel_d,
  input  dpath_pkg::alu_fn_t   alu_fn_x,
  input  dpath_pkg::brj_sel_t  brj_sel_x,
  input  logic                 brj_taken_x,
  input  dpath_pkg::word_t     dmem_rdata,
  input  dpath_pkg::load_sel_t load_sel_m,
  input  dpath_pkg::wb_sel_t   wb_sel_m,
  input  logic                 rf_wen_w,
  input  dpath_pkg::reg_addr_t rf_waddr_w,
  output dpath_pkg::word_t     imem_addr,
  output dpath_pkg::word_t     dmem_addr,
  output dpath_pkg::word_t     dmem_wdata,
  output dpath_pkg::word_t     wb_data,
  output logic                 cond_eq_x,
  output logic                 cond_ne_x,
  output logic                 cond_lt_x,
  output logic                 cond_ltu_x,
  output logic                 cond_ge_x,
  output logic                 cond_geu_x
);

  dpath_pkg::word_t pc_d, pc_plus4_d;                 // F to D
  dpath_pkg::word_t pc_x, op0_x, op1_x, rs1_x, rs2_x;  // D to X
  dpath_pkg::word_t imm_i_x, imm_sb_x, imm_uj_x;
  dpath_pkg::word_t exe_m;                            // X to M
  dpath_pkg::word_t redirect_target;                  // X back to F
  logic             redirect_x;

  fetch_unit u_fetch (
    .clk             (clk),
    .reset           (reset),
    .stall           (stall),
    .redirect_x      (redirect_x),
    .redirect_target (redirect_target),
    .imem_addr       (imem_addr),
    .pc_d            (pc_d),
    .pc_plus4_d      (pc_plus4_d)
  );

  decode_unit u_decode (
    .clk        (clk),
    .reset      (reset),
    .stall      (stall),
    .inst_d     (inst_d),
    .pc_d       (pc_d),
    .pc_plus4_d (pc_plus4_d),
    .op0_sel_d  (op0_sel_d),
    .op1_sel_d  (op1_sel_d),
    .rf_wen_w   (rf_wen_w),
    .rf_waddr_w (rf_waddr_w),
    .wb_data    (wb_data),
    .pc_x       (pc_x),
    .op0_x      (op0_x),
    .op1_x      (op1_x),
    .rs1_x      (rs1_x),
    .rs2_x      (rs2_x),
    .imm_i_x    (imm_i_x),
    .imm_sb_x   (imm_sb_x),
    .imm_uj_x   (imm_uj_x)
  );

  execute_unit u_execute (
    .clk             (clk),
    .reset           (reset),
    .stall           (stall),
    .brj_taken_x     (brj_taken_x),
    .pc_x            (pc_x),
    .op0_x           (op0_x),
    .op1_x           (op1_x),
    .rs1_x           (rs1_x),
    .rs2_x           (rs2_x),
    .imm_i_x         (imm_i_x),
    .imm_sb_x        (imm_sb_x),
    .imm_uj_x        (imm_uj_x),
    .alu_fn_x        (alu_fn_x),
    .brj_sel_x       (brj_sel_x),
    .dmem_addr       (dmem_addr),
    .dmem_wdata      (dmem_wdata),
    .exe_m           (exe_m),
    .redirect_target (redirect_target),
    .redirect_x      (redirect_x),
    .cond_eq_x       (cond_eq_x),
    .cond_ne_x       (cond_ne_x),
    .cond_lt_x       (cond_lt_x),
    .cond_ltu_x      (cond_ltu_x),
    .cond_ge_x       (cond_ge_x),
    .cond_geu_x      (cond_geu_x)
  );

  memory_writeback u_mem_wb (
    .clk        (clk),
    .reset      (reset),
    .stall      (stall),
    .exe_m      (exe_m),
    .dmem_rdata (dmem_rdata),
    .load_sel_m (load_sel_m),
    .wb_sel_m   (wb_sel_m),
    .wb_data    (wb_data)
  );

endmodule

/* verif/core_dpath_checker.sv */
/* Concurrent checks on core_dpath, bound into the top level.
   Flag and stall checks are disabled while reset is high */

`timescale 1ns/10ps
`include "dpath_defines.svh"

module core_dpath_checker (
  input logic             clk,
  input logic             reset,
  input logic             stall,
  input dpath_pkg::word_t imem_addr,
  input logic             cond_eq_x,
  input logic             cond_ne_x,
  input logic             cond_lt_x,
  input logic             cond_ltu_x,
  input logic             cond_ge_x,
  input logic             cond_geu_x
);

  int fail_count = 0;  // Failed assertions so far, read by the testbench

  // First fetch after reset
  a_reset_vector: assert property (@(posedge clk)
    reset |=> imem_addr == `DPATH_RESET_VECTOR)
    else begin
      $error("imem_addr left reset away from the reset vector");
      fail_count++;
    end

  // Frozen PC
  a_stall_hold: assert property (@(posedge clk) disable iff (reset)
    stall |=> $stable(imem_addr))
    else begin
      $error("imem_addr moved during a stalled cycle");
      fail_count++;
    end

  // Complementary flag pairs
  a_eq_ne: assert property (@(posedge clk) disable iff (reset) cond_eq_x != cond_ne_x)
    else begin
      $error("cond_eq_x and cond_ne_x agree");
      fail_count++;
    end
  a_lt_ge: assert property (@(posedge clk) disable iff (reset) cond_lt_x != cond_ge_x)
    else begin
      $error("cond_lt_x and cond_ge_x agree");
      fail_count++;
    end
  a_ltu_geu: assert property (@(posedge clk) disable iff (reset) cond_ltu_x != cond_geu_x)
    else begin
      $error("cond_ltu_x and cond_geu_x agree");
      fail_count++;
    end

endmodule

bind core_dpath core_dpath_checker u_checker (
  .clk        (clk),
  .reset      (reset),
  .stall      (stall),
  .imem_addr  (imem_addr),
  .cond_eq_x  (cond_eq_x),
  .cond_ne_x  (cond_ne_x),
  .cond_lt_x  (cond_lt_x),
  .cond_ltu_x (cond_ltu_x),
  .cond_ge_x  (cond_ge_x),
  .cond_geu_x (cond_geu_x)
);

/* verif/tb_core_dpath.sv */
/* Random per-stage controls from an xorshift source, checked every cycle
   against a register-level model of the pipeline and register file.
   Registers are only read after the register_init pass has written them */

`timescale 1ns/10ps
`include "dpath_defines.svh"

module tb_core_dpath;

  // Stimulus modes, one per test
  localparam int MODE_PC    = 0;
  localparam int MODE_INIT  = 1;
  localparam int MODE_REDIR = 2;
  localparam int MODE_ALU   = 3;
  localparam int MODE_OPSEL = 4;
  localparam int MODE_FLAGS = 5;
  localparam int MODE_LOAD  = 6;

  logic                 clk;
  logic                 reset;
  logic                 stall;
  dpath_pkg::word_t     inst_d;
  dpath_pkg::op0_sel_t  op0_sel_d;
  dpath_pkg::op1_sel_t  op1_sel_d;
  dpath_pkg::alu_fn_t   alu_fn_x;
  dpath_pkg::brj_sel_t  brj_sel_x;
  logic                 brj_taken_x;
  dpath_pkg::word_t     dmem_rdata;
  dpath_pkg::load_sel_t load_sel_m;
  dpath_pkg::wb_sel_t   wb_sel_m;
  logic                 rf_wen_w;
  dpath_pkg::reg_addr_t rf_waddr_w;
  dpath_pkg::word_t     imem_addr, dmem_addr, dmem_wdata, wb_data;
  logic                 cond_eq_x, cond_ne_x, cond_lt_x, cond_ltu_x, cond_ge_x, cond_geu_x;

  // Model state, same register boundaries as the pipeline
  dpath_pkg::word_t rf_m [`DPATH_NUM_REGS];
  dpath_pkg::word_t pc_f, pc_d_m, pc4_d_m;                  // F and D
  dpath_pkg::word_t x_pc, x_op0, x_op1, x_rs1, x_rs2;       // X
  dpath_pkg::word_t x_imm_i, x_imm_sb, x_imm_uj;
  dpath_pkg::word_t m_exe, w_data;                          // M and W

  logic [31:0] seed;
  int          mode, init_idx, errors, test_errors, checks, tests;
  logic        released;

  core_dpath uut (
    .clk         (clk),
    .reset       (reset),
    .stall       (stall),
    .inst_d      (inst_d),
    .op0_sel_d   (op0_sel_d),
    .op1_sel_d   (op1_sel_d),
    .alu_fn_x    (alu_fn_x),
    .brj_sel_x   (brj_sel_x),
    .brj_taken_x (brj_taken_x),
    .dmem_rdata  (dmem_rdata),
    .load_sel_m  (load_sel_m),
    .wb_sel_m    (wb_sel_m),
    .rf_wen_w    (rf_wen_w),
    .rf_waddr_w  (rf_waddr_w),
    .imem_addr   (imem_addr),
    .dmem_addr   (dmem_addr),
    .dmem_wdata  (dmem_wdata),
    .wb_data     (wb_data),
    .cond_eq_x   (cond_eq_x),
    .cond_ne_x   (cond_ne_x),
    .cond_lt_x   (cond_lt_x),
    .cond_ltu_x  (cond_ltu_x),
    .cond_ge_x   (cond_ge_x),
    .cond_geu_x  (cond_geu_x)
  );

  always #50 clk = ~clk;  // 100 ns period

  // ------------------------------------------------------------------------
  // Random source and reference functions
  // ------------------------------------------------------------------------
  function automatic logic [31:0] rand_word();
    seed ^= seed << 13;
    seed ^= seed >> 17;
    seed ^= seed << 5;
    return seed;
  endfunction

  // Signed compare by sign bits, then magnitude
  function automatic logic less_signed(input dpath_pkg::word_t a, input dpath_pkg::word_t b);
    return (a[31] != b[31]) ? a[31] : (a < b);
  endfunction

  function automatic dpath_pkg::word_t alu_model(input dpath_pkg::alu_fn_t fn,
                                                 input dpath_pkg::word_t a,
                                                 input dpath_pkg::word_t b);
    logic [4:0] s;
    s = b[4:0];
    case (fn)
      dpath_pkg::ALU_ADD: return a + b;
      dpath_pkg::ALU_SUB: return a + ~b + 32'd1;  // Two's complement
      dpath_pkg::ALU_SLL: return a << s;
      dpath_pkg::ALU_OR:  return a | b;
      dpath_pkg::ALU_LT:  return {31'b0, less_signed(a, b)};
      dpath_pkg::ALU_LTU: return {31'b0, a < b};
      dpath_pkg::ALU_AND: return a & b;
      dpath_pkg::ALU_XOR: return a ^ b;
      dpath_pkg::ALU_NOR: return ~(a | b);
      dpath_pkg::ALU_SRL: return a >> s;
      dpath_pkg::ALU_SRA: return (a >> s) | (a[31] ? ~(32'hffffffff >> s) : 32'h0);
      default:            return '0;
    endcase
  endfunction

  function automatic dpath_pkg::word_t extract_load(input dpath_pkg::load_sel_t sel,
                                                    input dpath_pkg::word_t d);
    case (sel)
      dpath_pkg::LD_B:  return {{24{d[7]}}, d[7:0]};
      dpath_pkg::LD_BU: return {24'h0, d[7:0]};
      dpath_pkg::LD_H:  return {{16{d[15]}}, d[15:0]};
      dpath_pkg::LD_HU: return {16'h0, d[15:0]};
      default:          return d;
    endcase
  endfunction

  function automatic dpath_pkg::word_t read_reg(input dpath_pkg::reg_addr_t a);
    return (a == '0) ? '0 : rf_m[a];  // x0 hardwired
  endfunction

  task automatic check_word(input string name, input dpath_pkg::word_t got,
                            input dpath_pkg::word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // ------------------------------------------------------------------------
  // Cycle model, called right after each rising edge
  // ------------------------------------------------------------------------
  task automatic model_edge();
    dpath_pkg::word_t rs1v, rs2v, op0, op1, imm_i, imm_sb, imm_uj, tgt, alu_r, wbv;
    rs1v   = read_reg(inst_d[19:15]);  // Read before this edge's write
    rs2v   = read_reg(inst_d[24:20]);
    imm_i  = {{20{inst_d[31]}}, inst_d[31:20]};
    imm_sb = {{19{inst_d[31]}}, inst_d[31], inst_d[7], inst_d[30:25], inst_d[11:8], 1'b0};
    imm_uj = {{11{inst_d[31]}}, inst_d[31], inst_d[19:12], inst_d[20], inst_d[30:21], 1'b0};
    case (op0_sel_d)
      dpath_pkg::OP0_RDAT: op0 = rs1v;
      dpath_pkg::OP0_PC:   op0 = pc_d_m;
      dpath_pkg::OP0_PC4:  op0 = pc4_d_m;
      default:             op0 = '0;
    endcase
    case (op1_sel_d)
      dpath_pkg::OP1_RDAT:   op1 = rs2v;
      dpath_pkg::OP1_SHAMT:  op1 = {27'h0, inst_d[24:20]};
      dpath_pkg::OP1_IMM_U:  op1 = {inst_d[31:12], 12'h0};
      dpath_pkg::OP1_IMM_SB: op1 = imm_sb;
      dpath_pkg::OP1_IMM_I:  op1 = imm_i;
      dpath_pkg::OP1_IMM_S:  op1 = {{20{inst_d[31]}}, inst_d[31:25], inst_d[11:7]};
      default:               op1 = '0;
    endcase
    case (brj_sel_x)
      dpath_pkg::BRJ_BR:   tgt = x_pc + x_imm_sb;
      dpath_pkg::BRJ_JAL:  tgt = x_pc + x_imm_uj;
      dpath_pkg::BRJ_JALR: tgt = (x_rs1 + x_imm_i) & ~32'h1;
      default:             tgt = x_pc + `DPATH_PC_STEP;
    endcase
    alu_r = alu_model(alu_fn_x, x_op0, x_op1);
    wbv   = (wb_sel_m == dpath_pkg::WB_MEM) ? extract_load(load_sel_m, dmem_rdata) : m_exe;
    if (rf_wen_w && rf_waddr_w != '0) begin
      rf_m[rf_waddr_w] = w_data;  // Write ignores stall
    end
    if (reset) begin
      pc_f     = `DPATH_RESET_VECTOR;
      pc_d_m   = '0;
      pc4_d_m  = '0;
      x_pc     = '0;
      x_op0    = '0;
      x_op1    = '0;
      x_rs1    = '0;
      x_rs2    = '0;
      x_imm_i  = '0;
      x_imm_sb = '0;
      x_imm_uj = '0;
      m_exe    = '0;
      w_data   = '0;
    end else if (!stall) begin
      w_data   = wbv;
      m_exe    = alu_r;
      x_pc     = pc_d_m;  // Older D values move first
      x_op0    = op0;
      x_op1    = op1;
      x_rs1    = rs1v;
      x_rs2    = rs2v;
      x_imm_i  = imm_i;
      x_imm_sb = imm_sb;
      x_imm_uj = imm_uj;
      pc_d_m   = pc_f;
      pc4_d_m  = pc_f + `DPATH_PC_STEP;
      pc_f     = brj_taken_x ? tgt : pc_f + `DPATH_PC_STEP;
    end
  endtask

  // ------------------------------------------------------------------------
  // Stimulus, checks and test sequencing
  // ------------------------------------------------------------------------
  task automatic drive_inputs();
    logic [31:0] r, r2, inst;
    r    = rand_word();
    r2   = rand_word();
    inst = rand_word();
    if (mode <= MODE_INIT) begin
      inst = inst & 32'hfe007fff;  // rs1 and rs2 fields point at x0
    end
    if (mode == MODE_FLAGS && r[1:0] == 2'd0) begin
      inst[24:20] = inst[19:15];  // Equal operands
    end
    inst_d      <= inst;
    stall       <= (mode == MODE_INIT) ? 1'b0 : (r[7:4] < ((mode == MODE_PC) ? 4 : 2));
    brj_taken_x <= (mode == MODE_REDIR) && (r[11:8] < 5);
    brj_sel_x   <= dpath_pkg::brj_sel_t'(r[15:12] % 3 + 1);
    dmem_rdata  <= rand_word();
    load_sel_m  <= dpath_pkg::load_sel_t'(r2[15:8] % 5);
    if (mode == MODE_INIT) begin
      op0_sel_d  <= dpath_pkg::OP0_ZERO;  // ZERO plus imm_i
      op1_sel_d  <= dpath_pkg::OP1_IMM_I;
      alu_fn_x   <= dpath_pkg::ALU_ADD;
      wb_sel_m   <= dpath_pkg::WB_EXE;
      rf_wen_w   <= 1'b1;
      rf_waddr_w <= init_idx[4:0];
      init_idx++;
    end else begin
      op0_sel_d  <= (mode == MODE_FLAGS && r[3]) ? dpath_pkg::OP0_RDAT
                                                 : dpath_pkg::op0_sel_t'(r[21:20]);
      op1_sel_d  <= (mode == MODE_FLAGS && r[3]) ? dpath_pkg::OP1_RDAT
                                                 : dpath_pkg::op1_sel_t'(r[24:22] % 7);
      alu_fn_x   <= (mode == MODE_OPSEL) ? dpath_pkg::ALU_ADD
                                         : dpath_pkg::alu_fn_t'(r[28:25] % 11);
      wb_sel_m   <= (mode == MODE_LOAD) ? dpath_pkg::WB_MEM :
                    (mode == MODE_ALU)  ? dpath_pkg::WB_EXE : dpath_pkg::wb_sel_t'(r[29]);
      rf_wen_w   <= (mode != MODE_PC) && (r2[1:0] != 2'd0);
      rf_waddr_w <= r2[6:2];  // x0 included
    end
  endtask

  // Comb outputs against model state, sampled mid-cycle
  task automatic check_outputs();
    check_word("imem_addr", imem_addr, pc_f);
    check_word("dmem_addr", dmem_addr, alu_model(alu_fn_x, x_op0, x_op1));
    check_word("dmem_wdata", dmem_wdata, x_rs2);
    check_word("wb_data", wb_data, w_data);
    check_flag("cond_eq_x", cond_eq_x, x_op0 == x_op1);
    check_flag("cond_ne_x", cond_ne_x, x_op0 != x_op1);
    check_flag("cond_lt_x", cond_lt_x, less_signed(x_op0, x_op1));
    check_flag("cond_ltu_x", cond_ltu_x, x_op0 < x_op1);
    check_flag("cond_ge_x", cond_ge_x, !less_signed(x_op0, x_op1));
    check_flag("cond_geu_x", cond_geu_x, !(x_op0 < x_op1));
  endtask

  task automatic run_test(input string name, input int test_mode, input int cycles);
    int i;
    mode        = test_mode;
    test_errors = 0;
    for (i = 0; i < cycles; i++) begin
      @(posedge clk);
      model_edge();
      drive_inputs();
      @(negedge clk);
      check_outputs();
    end
    tests++;
    $display("test %-15s %0d cycles, %0d errors", name, cycles, test_errors);
  endtask

  task automatic wait_reset_release(output logic ok);
    int n;
    n = 0;
    while (reset !== 1'b0 && n < 20) begin
      @(negedge clk);
      n++;
    end
    ok = (reset === 1'b0);
  endtask

  initial begin
    int i;
    clk         = 1'b0;
    reset       = 1'b1;
    stall       = 1'b0;
    inst_d      = '0;
    op0_sel_d   = dpath_pkg::OP0_RDAT;
    op1_sel_d   = dpath_pkg::OP1_RDAT;
    alu_fn_x    = dpath_pkg::ALU_ADD;
    brj_sel_x   = dpath_pkg::BRJ_BR;
    brj_taken_x = 1'b0;
    dmem_rdata  = '0;
    load_sel_m  = dpath_pkg::LD_W;
    wb_sel_m    = dpath_pkg::WB_EXE;
    rf_wen_w    = 1'b0;
    rf_waddr_w  = '0;
    seed        = 32'hacbad3f5;
    init_idx    = 0;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    for (i = 0; i < 5; i++) begin
      @(posedge clk);
      model_edge();
    end
    reset <= 1'b0;
    wait_reset_release(released);
    if (!released) begin
      $display("Timeout: reset still high 20 cycles after release");
      errors++;
    end else begin
      check_word("imem_addr", imem_addr, `DPATH_RESET_VECTOR);  // First fetch
      check_outputs();
      run_test("pc_sequencing", MODE_PC, 60);
      run_test("register_init", MODE_INIT, 32);
      run_test("redirects", MODE_REDIR, 80);
      run_test("alu_writeback", MODE_ALU, 150);
      run_test("operand_select", MODE_OPSEL, 80);
      run_test("branch_flags", MODE_FLAGS, 80);
      run_test("loads", MODE_LOAD, 80);
    end
    // Assertion failures of the bound checker count as errors
    if (uut.u_checker.fail_count != 0) begin
      $display("Bound checker saw %0d assertion failures", uut.u_checker.fail_count);
      errors += uut.u_checker.fail_count;
    end
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+common
common/dpath_pkg.sv
src/fetch_unit.sv
decode/regfile.sv
decode/decode_unit.sv
execute/alu.sv
execute/execute_unit.sv
src/memory_writeback.sv
src/core_dpath.sv
verif/core_dpath_checker.sv
verif/tb_core_dpath.sv

/* Bender.yml */
package:
  name: core_dpath

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/dpath_pkg.sv
      - src/fetch_unit.sv
      - decode/regfile.sv
      - decode/decode_unit.sv
      - execute/alu.sv
      - execute/execute_unit.sv
      - src/memory_writeback.sv
      - src/core_dpath.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/core_dpath_checker.sv
      - verif/tb_core_dpath.sv
